// ==== src/eth_dma_defines.svh ====
/*
 * Ethernet TX DMA constants
 * Preamble layout, burst limit, descriptor bit positions and bus widths
 */
`ifndef ETH_DMA_DEFINES_SVH
`define ETH_DMA_DEFINES_SVH

// Frame buffer head
`define ETH_PREAMBLE_LEN  7
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE      8'hD5
`define ETH_PRE_FRAME_LEN 8

// AXI read side with byte beats
`define ETH_MAX_BURST     16
`define ETH_AXI_ADDR_W    32
`define ETH_AXI_DATA_W    32
`define ETH_AXI_LEN_W     8

// Descriptor memory holds 16 descriptors of two words
`define ETH_BD_ADDR_W     5
`define ETH_BUF_ADDR_W    11

// Control word bits
`define ETH_BD_READY_BIT  15
`define ETH_BD_IRQ_BIT    14
`define ETH_BD_WRAP_BIT   13
`define ETH_BD_CRC_BIT    11

`endif

// ==== src/eth_bd_pkg.sv ====
/*
 * Descriptor-side types
 * Word, address, index and length types plus the fetch FSM states
 */
`include "eth_dma_defines.svh"

package eth_bd_pkg;

   // One 32-bit descriptor word
   typedef logic [31:0] bd_word_t;

   // Word address into descriptor memory
   typedef logic [`ETH_BD_ADDR_W-1:0] bd_addr_t;

   // Descriptor index, two words per descriptor
   typedef logic [`ETH_BD_ADDR_W-2:0] bd_num_t;

   // Length field from control word bits 31..16
   typedef logic [15:0] frame_len_t;

   // Descriptor fetch and writeback FSM
   typedef enum logic [2:0] {
      RD_CTRL,
      CHK_CTRL,
      RD_PTR,
      LATCH_PTR,
      DISPATCH,
      WAIT_DONE,
      WR_STATUS
   } fetch_state_e;

endpackage

// ==== src/eth_bus_pkg.sv ====
/*
 * External bus and frame buffer types, plus the copy FSM states
 */
`include "eth_dma_defines.svh"

package eth_bus_pkg;

   typedef logic [`ETH_AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [`ETH_AXI_DATA_W-1:0] axi_data_t;
   typedef logic [`ETH_AXI_LEN_W-1:0]  axi_len_t;
   typedef logic [`ETH_BUF_ADDR_W-1:0] buf_addr_t;
   typedef logic [7:0]                 byte_t;

   // Preamble fill first, then idle and burst copy
   typedef enum logic [2:0] {
      FILL,
      IDLE,
      ADDR,
      DATA,
      HANDOFF
   } burst_state_e;

endpackage

// ==== src/eth_tx_bd_decode.sv ====
/*
 * TX descriptor decode
 * Fetches descriptors from the ring, issues copy jobs and writes status back
 */
`timescale 1ns/100ps
`include "eth_dma_defines.svh"

module eth_tx_bd_decode (
   input  logic                   clk_i,
   input  logic                   arst_i,
   input  logic                   tx_en_i,
   input  eth_bd_pkg::bd_word_t   bd_rdata_i,
   input  logic                   job_ready_i,
   input  logic                   sent_i,
   output eth_bd_pkg::bd_addr_t   bd_addr_o,
   output logic                   bd_wen_o,
   output eth_bd_pkg::bd_word_t   bd_wdata_o,
   output logic                   job_valid_o,
   output eth_bus_pkg::axi_addr_t job_ptr_o,
   output eth_bd_pkg::frame_len_t job_len_o,
   output logic                   job_crc_en_o,
   output logic                   tx_irq_o
);

   eth_bd_pkg::fetch_state_e state_q;
   eth_bd_pkg::fetch_state_e state_d;
   eth_bd_pkg::bd_num_t      bd_num_q;
   eth_bd_pkg::bd_word_t     ctrl_q;
   eth_bus_pkg::axi_addr_t   ptr_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         eth_bd_pkg::RD_CTRL: begin
            state_d = eth_bd_pkg::CHK_CTRL;
         end
         eth_bd_pkg::CHK_CTRL: begin
            // Poll the same descriptor again while not ready or TX is off
            if (bd_rdata_i[`ETH_BD_READY_BIT] && tx_en_i) begin
               state_d = eth_bd_pkg::RD_PTR;
            end else begin
               state_d = eth_bd_pkg::RD_CTRL;
            end
         end
         eth_bd_pkg::RD_PTR: begin
            state_d = eth_bd_pkg::LATCH_PTR;
         end
         eth_bd_pkg::LATCH_PTR: begin
            state_d = eth_bd_pkg::DISPATCH;
         end
         eth_bd_pkg::DISPATCH: begin
            if (job_ready_i) begin
               state_d = eth_bd_pkg::WAIT_DONE;
            end
         end
         eth_bd_pkg::WAIT_DONE: begin
            if (sent_i) begin
               state_d = eth_bd_pkg::WR_STATUS;
            end
         end
         eth_bd_pkg::WR_STATUS: begin
            state_d = eth_bd_pkg::RD_CTRL;
         end
         default: begin
            state_d = eth_bd_pkg::RD_CTRL;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q  <= eth_bd_pkg::RD_CTRL;
         bd_num_q <= '0;
         ctrl_q   <= '0;
         ptr_q    <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == eth_bd_pkg::CHK_CTRL) begin
            ctrl_q <= bd_rdata_i;
         end
         if (state_q == eth_bd_pkg::LATCH_PTR) begin
            ptr_q <= eth_bus_pkg::axi_addr_t'(bd_rdata_i);
         end
         // Wrap bit or last slot returns the ring to 0
         if (state_q == eth_bd_pkg::WR_STATUS) begin
            if (ctrl_q[`ETH_BD_WRAP_BIT] || (&bd_num_q)) begin
               bd_num_q <= '0;
            end else begin
               bd_num_q <= bd_num_q + 1'b1;
            end
         end
      end
   end

   // Word 2n is control, word 2n+1 is the frame pointer
   assign bd_addr_o = {bd_num_q, state_q == eth_bd_pkg::RD_PTR};
   assign bd_wen_o  = (state_q == eth_bd_pkg::WR_STATUS);
   assign tx_irq_o  = bd_wen_o && ctrl_q[`ETH_BD_IRQ_BIT];

   always_comb begin
      bd_wdata_o                    = ctrl_q;
      bd_wdata_o[`ETH_BD_READY_BIT] = 1'b0;
   end

   assign job_valid_o  = (state_q == eth_bd_pkg::DISPATCH);
   assign job_ptr_o    = ptr_q;
   assign job_len_o    = ctrl_q[31:16];
   assign job_crc_en_o = ctrl_q[`ETH_BD_CRC_BIT];

endmodule

// ==== src/eth_tx_burst_exec.sv ====
/*
 * TX burst engine
 * Writes preamble and SFD after reset, then copies frames over AXI read bursts
 */
`timescale 1ns/100ps
`include "eth_dma_defines.svh"

module eth_tx_burst_exec (
   input  logic                   clk_i,
   input  logic                   arst_i,
   input  logic                   job_valid_i,
   input  eth_bus_pkg::axi_addr_t job_ptr_i,
   input  eth_bd_pkg::frame_len_t job_len_i,
   input  logic                   job_crc_en_i,
   input  logic                   buf_free_i,
   input  logic                   arready_i,
   input  logic                   rvalid_i,
   input  eth_bus_pkg::axi_data_t rdata_i,
   input  logic                   rlast_i,
   input  logic                   frame_ready_i,
   output logic                   job_ready_o,
   output eth_bus_pkg::axi_addr_t araddr_o,
   output eth_bus_pkg::axi_len_t  arlen_o,
   output logic                   arvalid_o,
   output logic                   rready_o,
   output logic                   buf_wen_o,
   output eth_bus_pkg::buf_addr_t buf_addr_o,
   output eth_bus_pkg::byte_t     buf_wdata_o,
   output logic                   frame_valid_o,
   output eth_bd_pkg::frame_len_t frame_len_o,
   output logic                   frame_crc_en_o
);

   eth_bus_pkg::burst_state_e state_q;
   eth_bus_pkg::burst_state_e state_d;
   eth_bd_pkg::frame_len_t    byte_cnt_q;
   eth_bd_pkg::frame_len_t    len_q;
   eth_bus_pkg::axi_addr_t    ptr_q;
   logic                      crc_en_q;
   eth_bd_pkg::frame_len_t    remaining;
   eth_bd_pkg::frame_len_t    beats;
   eth_bus_pkg::axi_addr_t    cur_addr;
   logic                      beat;
   logic                      fill_last;
   logic                      job_take;

   assign remaining = len_q - byte_cnt_q;
   assign beats     = (remaining > eth_bd_pkg::frame_len_t'(`ETH_MAX_BURST)) ?
                      eth_bd_pkg::frame_len_t'(`ETH_MAX_BURST) : remaining;
   assign cur_addr  = ptr_q + eth_bus_pkg::axi_addr_t'(byte_cnt_q);
   assign beat      = (state_q == eth_bus_pkg::DATA) && rvalid_i;
   // SFD sits right after the preamble bytes
   assign fill_last = (byte_cnt_q == eth_bd_pkg::frame_len_t'(`ETH_PREAMBLE_LEN));
   assign job_take  = job_valid_i && job_ready_o;

   assign job_ready_o    = (state_q == eth_bus_pkg::IDLE) && buf_free_i;
   assign arvalid_o      = (state_q == eth_bus_pkg::ADDR);
   assign araddr_o       = cur_addr;
   assign arlen_o        = eth_bus_pkg::axi_len_t'(beats - 1'b1);
   assign rready_o       = (state_q == eth_bus_pkg::DATA);
   assign frame_valid_o  = (state_q == eth_bus_pkg::HANDOFF);
   assign frame_len_o    = len_q;
   assign frame_crc_en_o = crc_en_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         eth_bus_pkg::FILL: begin
            if (fill_last) begin
               state_d = eth_bus_pkg::IDLE;
            end
         end
         eth_bus_pkg::IDLE: begin
            if (job_take) begin
               state_d = (job_len_i == '0) ? eth_bus_pkg::HANDOFF : eth_bus_pkg::ADDR;
            end
         end
         eth_bus_pkg::ADDR: begin
            if (arready_i) begin
               state_d = eth_bus_pkg::DATA;
            end
         end
         eth_bus_pkg::DATA: begin
            // More bytes left after a burst means another address phase
            if (beat && rlast_i) begin
               if (byte_cnt_q + 1'b1 == len_q) begin
                  state_d = eth_bus_pkg::HANDOFF;
               end else begin
                  state_d = eth_bus_pkg::ADDR;
               end
            end
         end
         eth_bus_pkg::HANDOFF: begin
            if (frame_ready_i) begin
               state_d = eth_bus_pkg::IDLE;
            end
         end
         default: begin
            state_d = eth_bus_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q    <= eth_bus_pkg::FILL;
         byte_cnt_q <= '0;
         len_q      <= '0;
         ptr_q      <= '0;
         crc_en_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         if (job_take) begin
            byte_cnt_q <= '0;
            len_q      <= job_len_i;
            ptr_q      <= job_ptr_i;
            crc_en_q   <= job_crc_en_i;
         end else if ((state_q == eth_bus_pkg::FILL) || beat) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
         end
      end
   end

   // Buffer write port trails the fill count or the beat by one cycle
   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         buf_wen_o   <= 1'b0;
         buf_addr_o  <= '0;
         buf_wdata_o <= '0;
      end else begin
         buf_wen_o <= (state_q == eth_bus_pkg::FILL) || beat;
         if (state_q == eth_bus_pkg::FILL) begin
            buf_addr_o  <= eth_bus_pkg::buf_addr_t'(byte_cnt_q);
            buf_wdata_o <= fill_last ? `ETH_SFD_BYTE : `ETH_PREAMBLE_BYTE;
         end else if (beat) begin
            buf_addr_o  <= eth_bus_pkg::buf_addr_t'(`ETH_PRE_FRAME_LEN) +
                           eth_bus_pkg::buf_addr_t'(byte_cnt_q);
            // Byte lane follows the low address bits
            buf_wdata_o <= rdata_i[{cur_addr[1:0], 3'b000} +: 8];
         end
      end
   end

endmodule

// ==== src/eth_tx_send_ctrl.sv ====
/*
 * MAC send handshake
 * Raises send for a finished frame and tracks when the frame buffer is free
 */
`timescale 1ns/100ps
`include "eth_dma_defines.svh"

module eth_tx_send_ctrl (
   input  logic                   clk_i,
   input  logic                   arst_i,
   input  logic                   frame_valid_i,
   input  eth_bd_pkg::frame_len_t frame_len_i,
   input  logic                   frame_crc_en_i,
   input  logic                   tx_ready_i,
   output logic                   frame_ready_o,
   output logic                   buf_free_o,
   output logic                   sent_o,
   output logic                   send_o,
   output logic [10:0]            tx_nbytes_o,
   output logic                   crc_en_o
);

   // Set from frame accept until the MAC is ready again
   logic pending_q;

   assign frame_ready_o = !pending_q;
   assign buf_free_o    = !pending_q && tx_ready_i;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         pending_q   <= 1'b0;
         send_o      <= 1'b0;
         sent_o      <= 1'b0;
         tx_nbytes_o <= '0;
         crc_en_o    <= 1'b0;
      end else begin
         // MAC took the frame when ready drops under send
         sent_o <= send_o && !tx_ready_i;
         if (frame_valid_i && frame_ready_o) begin
            pending_q   <= 1'b1;
            send_o      <= 1'b1;
            tx_nbytes_o <= 11'(`ETH_PRE_FRAME_LEN) + frame_len_i[10:0];
            crc_en_o    <= frame_crc_en_i;
         end else if (send_o && !tx_ready_i) begin
            send_o <= 1'b0;
         end else if (pending_q && !send_o && tx_ready_i) begin
            pending_q <= 1'b0;
         end
      end
   end

endmodule

// ==== src/eth_tx_dma.sv ====
/*
 * Ethernet TX DMA top
 * Descriptor decode, burst copy and MAC send stages
 */
`timescale 1ns/100ps

module eth_tx_dma (
   input  logic                   clk_i,
   input  logic                   arst_i,
   input  logic                   tx_en_i,
   input  eth_bd_pkg::bd_word_t   bd_rdata_i,
   input  logic                   arready_i,
   input  logic                   rvalid_i,
   input  eth_bus_pkg::axi_data_t rdata_i,
   input  logic                   rlast_i,
   input  logic                   tx_ready_i,
   output eth_bd_pkg::bd_addr_t   bd_addr_o,
   output logic                   bd_wen_o,
   output eth_bd_pkg::bd_word_t   bd_wdata_o,
   output eth_bus_pkg::axi_addr_t araddr_o,
   output eth_bus_pkg::axi_len_t  arlen_o,
   output logic                   arvalid_o,
   output logic                   rready_o,
   output logic                   buf_wen_o,
   output eth_bus_pkg::buf_addr_t buf_addr_o,
   output eth_bus_pkg::byte_t     buf_wdata_o,
   output logic                   send_o,
   output logic [10:0]            tx_nbytes_o,
   output logic                   crc_en_o,
   output logic                   tx_irq_o
);

   // Decode to execute
   logic                   job_valid;
   logic                   job_ready;
   eth_bus_pkg::axi_addr_t job_ptr;
   eth_bd_pkg::frame_len_t job_len;
   logic                   job_crc_en;

   // Execute to result
   logic                   frame_valid;
   logic                   frame_ready;
   eth_bd_pkg::frame_len_t frame_len;
   logic                   frame_crc_en;

   // Result back to the other stages
   logic                   buf_free;
   logic                   sent;

   eth_tx_bd_decode i_decode (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .tx_en_i      (tx_en_i),
      .bd_rdata_i   (bd_rdata_i),
      .job_ready_i  (job_ready),
      .sent_i       (sent),
      .bd_addr_o    (bd_addr_o),
      .bd_wen_o     (bd_wen_o),
      .bd_wdata_o   (bd_wdata_o),
      .job_valid_o  (job_valid),
      .job_ptr_o    (job_ptr),
      .job_len_o    (job_len),
      .job_crc_en_o (job_crc_en),
      .tx_irq_o     (tx_irq_o)
   );

   eth_tx_burst_exec i_exec (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .job_valid_i    (job_valid),
      .job_ptr_i      (job_ptr),
      .job_len_i      (job_len),
      .job_crc_en_i   (job_crc_en),
      .buf_free_i     (buf_free),
      .arready_i      (arready_i),
      .rvalid_i       (rvalid_i),
      .rdata_i        (rdata_i),
      .rlast_i        (rlast_i),
      .frame_ready_i  (frame_ready),
      .job_ready_o    (job_ready),
      .araddr_o       (araddr_o),
      .arlen_o        (arlen_o),
      .arvalid_o      (arvalid_o),
      .rready_o       (rready_o),
      .buf_wen_o      (buf_wen_o),
      .buf_addr_o     (buf_addr_o),
      .buf_wdata_o    (buf_wdata_o),
      .frame_valid_o  (frame_valid),
      .frame_len_o    (frame_len),
      .frame_crc_en_o (frame_crc_en)
   );

   eth_tx_send_ctrl i_send (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .frame_valid_i  (frame_valid),
      .frame_len_i    (frame_len),
      .frame_crc_en_i (frame_crc_en),
      .tx_ready_i     (tx_ready_i),
      .frame_ready_o  (frame_ready),
      .buf_free_o     (buf_free),
      .sent_o         (sent),
      .send_o         (send_o),
      .tx_nbytes_o    (tx_nbytes_o),
      .crc_en_o       (crc_en_o)
   );

endmodule

// ==== verif/eth_tx_dma_checker.sv ====
/*
 * TX DMA protocol checker bound into the top level
 */
`timescale 1ns/100ps

module eth_tx_dma_checker (
   input logic                   clk_i,
   input logic                   arst_i,
   input logic                   arvalid_o,
   input logic                   arready_i,
   input eth_bus_pkg::axi_addr_t araddr_o,
   input eth_bus_pkg::axi_len_t  arlen_o,
   input logic                   rready_o,
   input logic                   send_o,
   input logic                   tx_ready_i,
   input logic                   tx_irq_o,
   input logic                   bd_wen_o,
   input logic                   buf_wen_o,
   input logic                   sent_i
);

   // Count of failed assertions
   int unsigned fail_cnt = 0;

   // Address phase holds until accepted
   ar_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arlen_o))
   else begin
      $error("AR channel changed before arready");
      fail_cnt++;
   end

   // MAC must drop ready before send may fall
   send_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      send_o && tx_ready_i |=> send_o)
   else begin
      $error("send fell while the MAC was still ready");
      fail_cnt++;
   end

   // Status write and interrupt come only in the cycle after sent
   irq_with_wb: assert property (@(posedge clk_i) disable iff (arst_i)
      tx_irq_o || bd_wen_o |-> bd_wen_o && $past(sent_i))
   else begin
      $error("tx_irq or status write outside the cycle after sent");
      fail_cnt++;
   end

   no_unknown: assert property (@(posedge clk_i) disable iff (arst_i)
      !$isunknown({arvalid_o, araddr_o, arlen_o, rready_o, send_o, tx_irq_o,
                   bd_wen_o, buf_wen_o}))
   else begin
      $error("unknown value on a DMA output");
      fail_cnt++;
   end

endmodule

bind eth_tx_dma eth_tx_dma_checker i_checker (
   .clk_i      (clk_i),
   .arst_i     (arst_i),
   .arvalid_o  (arvalid_o),
   .arready_i  (arready_i),
   .araddr_o   (araddr_o),
   .arlen_o    (arlen_o),
   .rready_o   (rready_o),
   .send_o     (send_o),
   .tx_ready_i (tx_ready_i),
   .tx_irq_o   (tx_irq_o),
   .bd_wen_o   (bd_wen_o),
   .buf_wen_o  (buf_wen_o),
   .sent_i     (sent)
);

// ==== verif/eth_tx_dma_tb.sv ====
/*
 * Ethernet TX DMA testbench
 * Descriptor memory, AXI read slave and MAC models with data checks
 */
`timescale 1ns/100ps

module eth_tx_dma_tb;

   localparam int NUM_FRAMES = 3;

   logic        clk_i;
   logic        arst_i;
   logic        tx_en_i;
   logic [31:0] bd_rdata_i;
   logic        arready_i;
   logic        rvalid_i;
   logic [31:0] rdata_i;
   logic        rlast_i;
   logic        tx_ready_i;
   logic [4:0]  bd_addr_o;
   logic        bd_wen_o;
   logic [31:0] bd_wdata_o;
   logic [31:0] araddr_o;
   logic [7:0]  arlen_o;
   logic        arvalid_o;
   logic        rready_o;
   logic        buf_wen_o;
   logic [10:0] buf_addr_o;
   logic [7:0]  buf_wdata_o;
   logic        send_o;
   logic [10:0] tx_nbytes_o;
   logic        crc_en_o;
   logic        tx_irq_o;

   // Models
   logic [31:0] bd_mem [0:31];
   logic [7:0]  ext_mem [0:1023];
   logic [7:0]  frame_buf [0:2047];
   logic [31:0] fq_ctrl [0:NUM_FRAMES-1];
   logic [31:0] fq_ptr [0:NUM_FRAMES-1];
   logic [4:0]  bd_addr_q;
   logic [15:0] lfsr_q;
   logic [31:0] r_addr;
   logic [31:0] ar_addr_q;
   logic [7:0]  ar_len_q;
   logic        ar_seen;
   logic        send_q;
   logic        desc1_armed;
   logic        next_chk;
   int unsigned ar_cnt;
   int unsigned r_left;
   int unsigned mac_cnt;
   int unsigned mac_st;
   int unsigned next_idx;

   // Scoreboard state
   int unsigned fill_cnt;
   int unsigned copy_f;
   int unsigned wr_done;
   int unsigned ar_sum;
   int unsigned send_f;
   int unsigned status_f;
   int unsigned err_cnt;
   int unsigned test_cnt;
   int unsigned pass_cnt;
   int unsigned cycles;
   int unsigned cycle_limit;

   eth_tx_dma i_dut (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .tx_en_i     (tx_en_i),
      .bd_rdata_i  (bd_rdata_i),
      .arready_i   (arready_i),
      .rvalid_i    (rvalid_i),
      .rdata_i     (rdata_i),
      .rlast_i     (rlast_i),
      .tx_ready_i  (tx_ready_i),
      .bd_addr_o   (bd_addr_o),
      .bd_wen_o    (bd_wen_o),
      .bd_wdata_o  (bd_wdata_o),
      .araddr_o    (araddr_o),
      .arlen_o     (arlen_o),
      .arvalid_o   (arvalid_o),
      .rready_o    (rready_o),
      .buf_wen_o   (buf_wen_o),
      .buf_addr_o  (buf_addr_o),
      .buf_wdata_o (buf_wdata_o),
      .send_o      (send_o),
      .tx_nbytes_o (tx_nbytes_o),
      .crc_en_o    (crc_en_o),
      .tx_irq_o    (tx_irq_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
   endfunction

   // One LFSR step per bit taken
   function automatic int unsigned take_bits(input int n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v = (v << 1) | {31'b0, lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

   // Aligned 32-bit word around a byte address
   function automatic logic [31:0] word_at(input logic [31:0] a);
      logic [31:0] w;
      for (int i = 0; i < 4; i++) begin
         w[8*i +: 8] = ext_mem[{a[9:2], i[1:0]}];
      end
      return w;
   endfunction

   function automatic int unsigned total_errors();
      return err_cnt + i_dut.i_checker.fail_cnt;
   endfunction

   task automatic mismatch(input string msg);
      $display("Mismatch at %0t: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic report_test(input string name, input int unsigned start);
      test_cnt++;
      if (total_errors() == start) begin
         pass_cnt++;
         $display("PASS %s", name);
      end else begin
         $display("FAIL %s with %0d errors", name, total_errors() - start);
      end
   endtask

   // Read data one cycle after the address
   task automatic bd_model();
      if (bd_wen_o) begin
         bd_mem[bd_addr_o] = bd_wdata_o;
      end
      bd_rdata_i = bd_mem[bd_addr_q];
      bd_addr_q  = bd_addr_o;
   endtask

   task automatic check_burst();
      int unsigned len;
      int unsigned beats;
      if (copy_f >= NUM_FRAMES) begin
         $display("Read burst issued with no descriptor pending at %0t", $time);
         err_cnt++;
      end else begin
         len   = fq_ctrl[copy_f][31:16];
         beats = (len - ar_sum > 16) ? 16 : len - ar_sum;
         assert (arlen_o == 8'(beats - 1))
         else mismatch($sformatf("arlen %0d, expected %0d", arlen_o, beats - 1));
         assert (araddr_o == fq_ptr[copy_f] + ar_sum)
         else mismatch($sformatf("araddr %h, expected %h", araddr_o, fq_ptr[copy_f] + ar_sum));
         ar_sum += 32'(arlen_o) + 1;
      end
   endtask

   task automatic axi_model();
      // Beat taken at the last rising edge
      if (rvalid_i) begin
         r_addr = r_addr + 1;
         r_left = r_left - 1;
      end
      if (arready_i) begin
         arready_i = 1'b0;
         ar_seen   = 1'b0;
         r_addr    = ar_addr_q;
         r_left    = 32'(ar_len_q) + 1;
      end else if (arvalid_o) begin
         if (!ar_seen) begin
            ar_seen = 1'b1;
            ar_cnt  = take_bits(2);
            check_burst();
         end
         if (ar_cnt == 0) begin
            arready_i = 1'b1;
            ar_addr_q = araddr_o;
            ar_len_q  = arlen_o;
         end else begin
            ar_cnt--;
         end
      end
      // Data phase lasts until the last beat of the burst is taken
      if (r_left != 0) begin
         assert (rready_o) else mismatch("rready low during the data phase");
      end
      rvalid_i = 1'b0;
      rlast_i  = 1'b0;
      if (r_left != 0 && take_bits(2) != 0) begin
         rvalid_i = 1'b1;
         rdata_i  = word_at(r_addr);
         rlast_i  = (r_left == 1);
      end
   endtask

   // Ready drops a few cycles into send and comes back later
   task automatic mac_model();
      case (mac_st)
         0: begin
            if (send_o && tx_ready_i) begin
               mac_cnt = 1 + take_bits(2);
               mac_st  = 1;
            end
         end
         1: begin
            if (mac_cnt == 0) begin
               tx_ready_i = 1'b0;
               mac_cnt    = 2 + take_bits(3);
               mac_st     = 2;
            end else begin
               mac_cnt--;
            end
         end
         default: begin
            if (!send_o && mac_cnt == 0) begin
               tx_ready_i = 1'b1;
               mac_st     = 0;
            end else if (!send_o) begin
               mac_cnt--;
            end
         end
      endcase
   endtask

   task automatic frame_done();
      int unsigned len;
      len = fq_ctrl[copy_f][31:16];
      for (int k = 0; k < len; k++) begin
         assert (frame_buf[11'(8 + k)] == ext_mem[10'(fq_ptr[copy_f] + k)])
         else mismatch($sformatf("frame %0d byte %0d is %h", copy_f, k, frame_buf[11'(8 + k)]));
      end
      assert (ar_sum == len)
      else mismatch($sformatf("frame %0d bursts cover %0d of %0d bytes", copy_f, ar_sum, len));
      copy_f++;
      wr_done = 0;
      ar_sum  = 0;
   endtask

   task automatic score_outputs();
      if (buf_wen_o) begin
         frame_buf[buf_addr_o] = buf_wdata_o;
         if (fill_cnt < 8) begin
            assert (buf_addr_o == 11'(fill_cnt) &&
                    buf_wdata_o == ((fill_cnt < 7) ? 8'h55 : 8'hD5))
            else mismatch($sformatf("fill write %0d at %0d is %h", fill_cnt, buf_addr_o,
                                    buf_wdata_o));
            fill_cnt++;
         end else if (copy_f >= NUM_FRAMES) begin
            $display("Frame buffer written with no frame in copy at %0t", $time);
            err_cnt++;
         end else begin
            assert (buf_addr_o == 11'(8 + wr_done))
            else mismatch($sformatf("buffer address %0d, expected %0d", buf_addr_o, 8 + wr_done));
            wr_done++;
            if (wr_done == fq_ctrl[copy_f][31:16]) begin
               frame_done();
            end
         end
      end
      if (send_o && !send_q && send_f < NUM_FRAMES) begin
         assert (tx_nbytes_o == 11'(8 + fq_ctrl[send_f][31:16]) &&
                 crc_en_o == fq_ctrl[send_f][11])
         else mismatch($sformatf("send %0d nbytes %0d crc %b", send_f, tx_nbytes_o, crc_en_o));
         send_f++;
      end
      send_q = send_o;
      if (next_chk) begin
         assert (bd_addr_o == 5'(2 * next_idx))
         else mismatch($sformatf("next read at word %0d, expected %0d", bd_addr_o, 2 * next_idx));
         next_chk = 1'b0;
      end
      if (bd_wen_o && status_f < NUM_FRAMES) begin
         assert (bd_addr_o == 5'(2 * status_f) && bd_wdata_o == (fq_ctrl[status_f] & ~32'h8000))
         else mismatch($sformatf("status write %h at word %0d", bd_wdata_o, bd_addr_o));
         assert (tx_irq_o == fq_ctrl[status_f][14])
         else mismatch($sformatf("tx_irq %b for descriptor %0d", tx_irq_o, status_f));
         next_idx = fq_ctrl[status_f][13] ? 0 : status_f + 1;
         next_chk = 1'b1;
         status_f++;
      end else begin
         assert (!tx_irq_o) else mismatch("tx_irq outside a status write");
      end
      // Held descriptor or TX disabled
      if (!tx_en_i || (status_f == 1 && !desc1_armed)) begin
         assert (!arvalid_o) else mismatch("read burst while transmit is held");
      end
   endtask

   always @(negedge clk_i) begin
      bd_model();
      axi_model();
      mac_model();
      score_outputs();
   end

   always @(negedge clk_i) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, not all frames were sent", cycles);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      int unsigned start;
      int unsigned total_len;
      logic [15:0] len;
      logic [15:0] low;
      arst_i      = 1'b1;
      tx_en_i     = 1'b0;
      bd_rdata_i  = '0;
      arready_i   = 1'b0;
      rvalid_i    = 1'b0;
      rdata_i     = '0;
      rlast_i     = 1'b0;
      tx_ready_i  = 1'b1;
      lfsr_q      = 16'd36;
      bd_addr_q   = '0;
      r_addr      = '0;
      ar_addr_q   = '0;
      ar_len_q    = '0;
      ar_seen     = 1'b0;
      send_q      = 1'b0;
      desc1_armed = 1'b0;
      next_chk    = 1'b0;
      {ar_cnt, r_left, mac_cnt, mac_st, next_idx} = '0;
      {fill_cnt, copy_f, wr_done, ar_sum, send_f, status_f} = '0;
      {err_cnt, test_cnt, pass_cnt, cycles, total_len} = '0;
      cycle_limit = 2000;
      for (int i = 0; i < 32; i++) begin
         bd_mem[i] = '0;
      end
      for (int i = 0; i < 1024; i++) begin
         ext_mem[i] = 8'(take_bits(8));
      end
      for (int f = 0; f < NUM_FRAMES; f++) begin
         fq_ptr[f]  = 32'h8000_0000 + 32'(f * 128) + take_bits(2);
         len        = 16'(1 + take_bits(6) % 40);
         low        = 16'(take_bits(16));
         fq_ctrl[f] = {len, low};
         fq_ctrl[f][15] = 1'b1;
         // Only the last descriptor wraps the ring back to 0
         fq_ctrl[f][13] = (f == NUM_FRAMES - 1);
         bd_mem[2*f]   = fq_ctrl[f];
         bd_mem[2*f+1] = fq_ptr[f];
         total_len += 32'(len);
      end
      bd_mem[2][15] = 1'b0;
      cycle_limit   = 200 * total_len + 2000;

      repeat (10) @(negedge clk_i);
      arst_i = 1'b0;
      start  = total_errors();
      while (fill_cnt < 8) @(posedge clk_i);
      report_test("preamble and SFD fill", start);

      start = total_errors();
      repeat (40) @(negedge clk_i);
      tx_en_i = 1'b1;
      while (status_f < 1) @(posedge clk_i);
      report_test("frame 0 after TX enable", start);

      start = total_errors();
      repeat (30) @(posedge clk_i);
      bd_mem[2][15] = 1'b1;
      desc1_armed   = 1'b1;
      while (status_f < 2) @(posedge clk_i);
      report_test("frame 1 after late ready", start);

      start = total_errors();
      while (status_f < 3 || next_chk) @(posedge clk_i);
      report_test("frame 2 and ring step", start);

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
               test_cnt, pass_cnt, test_cnt - pass_cnt, total_errors());
      if (total_errors() == 0 && pass_cnt == test_cnt) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+src
src/eth_bd_pkg.sv
src/eth_bus_pkg.sv
src/eth_tx_bd_decode.sv
src/eth_tx_burst_exec.sv
src/eth_tx_send_ctrl.sv
src/eth_tx_dma.sv
verif/eth_tx_dma_checker.sv
verif/eth_tx_dma_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the Ethernet TX DMA testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module eth_tx_dma_tb -f sim.f -o eth_tx_dma_sim

# Keep running past assertion errors so the summary line is printed
./obj_dir/eth_tx_dma_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
   exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
